// ==== axil_iob_top.f ====
+incdir+verilog
verilog/axil_iob_pkg.sv
verilog/axil2iob_bridge.sv
verilog/iob_regbank.sv
verilog/axil_iob_top.sv
bench/axil_iob_tb.sv

// ==== bench/axil_iob_tb.sv ====
/* directed testbench for the AXI4-Lite to IOb register bank
   AXI-Lite master tasks, register model, watchdog and summary */

`timescale 1ns/10ps
`include "axil_iob_params.svh"

module axil_iob_tb;

   localparam int CLK_PERIOD = 20;
   // transactions per test in test order
   localparam int N_TRANS = 8 + 16 + 16 + 13 + 3 + 4;
   localparam int TIMEOUT_CYCLES = N_TRANS * 40 + 200;

   logic                    clk_i;
   logic                    reset_i;
   logic [`AXIL_ADDR_W-1:0] axil_awaddr_i;
   logic                    axil_awvalid_i;
   logic                    axil_awready_o;
   logic [`AXIL_DATA_W-1:0] axil_wdata_i;
   logic [`AXIL_STRB_W-1:0] axil_wstrb_i;
   logic                    axil_wvalid_i;
   logic                    axil_wready_o;
   logic [1:0]              axil_bresp_o;
   logic                    axil_bvalid_o;
   logic                    axil_bready_i;
   logic [`AXIL_ADDR_W-1:0] axil_araddr_i;
   logic                    axil_arvalid_i;
   logic                    axil_arready_o;
   logic [`AXIL_DATA_W-1:0] axil_rdata_o;
   logic [1:0]              axil_rresp_o;
   logic                    axil_rvalid_o;
   logic                    axil_rready_i;

   logic [`AXIL_DATA_W-1:0] model [`REGBANK_N]; // expected register contents
   logic [31:0]             rng;
   logic                    reset_quiet;
   int                      test_errs;
   int                      pass_cnt;
   int                      fail_cnt;

   axil_iob_top dut0 (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .axil_awaddr_i  (axil_awaddr_i),
      .axil_awvalid_i (axil_awvalid_i),
      .axil_awready_o (axil_awready_o),
      .axil_wdata_i   (axil_wdata_i),
      .axil_wstrb_i   (axil_wstrb_i),
      .axil_wvalid_i  (axil_wvalid_i),
      .axil_wready_o  (axil_wready_o),
      .axil_bresp_o   (axil_bresp_o),
      .axil_bvalid_o  (axil_bvalid_o),
      .axil_bready_i  (axil_bready_i),
      .axil_araddr_i  (axil_araddr_i),
      .axil_arvalid_i (axil_arvalid_i),
      .axil_arready_o (axil_arready_o),
      .axil_rdata_o   (axil_rdata_o),
      .axil_rresp_o   (axil_rresp_o),
      .axil_rvalid_o  (axil_rvalid_o),
      .axil_rready_i  (axil_rready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(CLK_PERIOD * TIMEOUT_CYCLES);
      $display("timeout: a transaction did not complete in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [`AXIL_ADDR_W-1:0] reg_addr(input int idx);
      return `AXIL_ADDR_W'(idx * 4);
   endfunction

   // page bits above index and byte offset select nothing when nonzero
   function automatic logic [`AXIL_DATA_W-1:0] model_read(input logic [`AXIL_ADDR_W-1:0] a);
      if (a[`AXIL_ADDR_W-1:5] != '0) begin
         return '0;
      end
      return model[a[4:2]];
   endfunction

   task automatic model_write(input logic [`AXIL_ADDR_W-1:0] a,
                              input logic [`AXIL_DATA_W-1:0] d,
                              input logic [`AXIL_STRB_W-1:0] s);
      if (a[`AXIL_ADDR_W-1:5] == '0) begin
         for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (s[b]) model[a[4:2]][8*b +: 8] = d[8*b +: 8];
         end
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      test_errs++;
   endtask

   task automatic finish_test(input string name);
      if (test_errs == 0) begin
         $display("%s: ok", name);
         pass_cnt++;
      end else begin
         $display("%s: %0d errors", name, test_errs);
         fail_cnt++;
      end
   endtask

   // aw and w raised together and bready held low for bready_dly cycles
   task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] a,
                             input logic [`AXIL_DATA_W-1:0] d,
                             input logic [`AXIL_STRB_W-1:0] s,
                             input int bready_dly, output logic [1:0] resp);
      logic aw_done;
      logic w_done;
      logic aw_hit;
      logic w_hit;
      aw_done = 1'b0;
      w_done  = 1'b0;
      @(posedge clk_i);
      axil_awaddr_i  <= a;
      axil_awvalid_i <= 1'b1;
      axil_wdata_i   <= d;
      axil_wstrb_i   <= s;
      axil_wvalid_i  <= 1'b1;
      while (!(aw_done && w_done)) begin
         @(negedge clk_i);
         aw_hit = axil_awready_o & axil_awvalid_i;
         w_hit  = axil_wready_o & axil_wvalid_i;
         @(posedge clk_i); // transfer edge when hit
         if (aw_hit) begin
            axil_awvalid_i <= 1'b0;
            aw_done = 1'b1;
         end
         if (w_hit) begin
            axil_wvalid_i <= 1'b0;
            w_done = 1'b1;
         end
      end
      do @(negedge clk_i); while (!axil_bvalid_o);
      resp = axil_bresp_o;
      repeat (bready_dly) begin
         @(negedge clk_i);
         if (axil_bvalid_o !== 1'b1) begin
            $display("bvalid dropped before bready was given");
            test_errs++;
         end
      end
      @(posedge clk_i);
      axil_bready_i <= 1'b1;
      @(posedge clk_i);
      axil_bready_i <= 1'b0;
   endtask

   task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] a, input int rready_dly,
                            output logic [`AXIL_DATA_W-1:0] d, output logic [1:0] resp);
      @(posedge clk_i);
      axil_araddr_i  <= a;
      axil_arvalid_i <= 1'b1;
      do @(negedge clk_i); while (!axil_arready_o);
      @(posedge clk_i);
      axil_arvalid_i <= 1'b0;
      do @(negedge clk_i); while (!axil_rvalid_o);
      d    = axil_rdata_o;
      resp = axil_rresp_o;
      repeat (rready_dly) begin
         @(negedge clk_i);
         if (axil_rvalid_o !== 1'b1 || axil_rdata_o !== d) begin
            $display("rvalid dropped or rdata changed while rready was low");
            test_errs++;
         end
      end
      @(posedge clk_i);
      axil_rready_i <= 1'b1;
      @(posedge clk_i);
      axil_rready_i <= 1'b0;
   endtask

   task automatic check_reset_state();
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              resp;
      test_errs = 0;
      if (!reset_quiet) begin
         $display("a ready or valid output was not low during reset");
         test_errs++;
      end
      for (int i = 0; i < `REGBANK_N; i++) begin
         axil_read(reg_addr(i), 0, rd, resp);
         if (rd !== '0) report_mismatch("reset_values", 32'h0, rd);
         if (resp !== 2'b00) report_mismatch("reset_values rresp", 32'h0, 32'(resp));
      end
      finish_test("reset_values");
   endtask

   task automatic write_read_words();
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              resp;
      test_errs = 0;
      for (int i = 0; i < `REGBANK_N; i++) begin
         rng = xorshift32(rng);
         axil_write(reg_addr(i), rng, '1, 0, resp);
         model_write(reg_addr(i), rng, '1);
         if (resp !== 2'b00) report_mismatch("full_words bresp", 32'h0, 32'(resp));
      end
      for (int i = 0; i < `REGBANK_N; i++) begin
         axil_read(reg_addr(i), 0, rd, resp);
         if (rd !== model[i]) report_mismatch("full_words", model[i], rd);
      end
      finish_test("full_words");
   endtask

   task automatic partial_strobes();
      logic [`AXIL_STRB_W-1:0] pattern [8];
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              resp;
      pattern = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                  4'b0011, 4'b1100, 4'b0101, 4'b1010};
      test_errs = 0;
      for (int i = 0; i < `REGBANK_N; i++) begin
         rng = xorshift32(rng);
         axil_write(reg_addr(i), rng, pattern[i], 0, resp);
         model_write(reg_addr(i), rng, pattern[i]);
      end
      for (int i = 0; i < `REGBANK_N; i++) begin
         axil_read(reg_addr(i), 0, rd, resp);
         if (rd !== model[i]) report_mismatch("partial_strobes", model[i], rd);
      end
      finish_test("partial_strobes");
   endtask

   task automatic unmapped_pages();
      logic [`AXIL_ADDR_W-1:0] far [4];
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              resp;
      far = '{8'h20, 8'h44, 8'hA8, 8'hFC};
      test_errs = 0;
      for (int i = 0; i < 4; i++) begin
         axil_read(far[i], 0, rd, resp);
         if (rd !== model_read(far[i])) begin
            report_mismatch("unmapped read", model_read(far[i]), rd);
         end
      end
      rng = xorshift32(rng);
      axil_write(8'h24, rng, '1, 0, resp); // page 1 would alias register 1
      model_write(8'h24, rng, '1);
      for (int i = 0; i < `REGBANK_N; i++) begin
         axil_read(reg_addr(i), 0, rd, resp);
         if (rd !== model_read(reg_addr(i))) begin
            report_mismatch("unmapped write", model_read(reg_addr(i)), rd);
         end
      end
      finish_test("unmapped_pages");
   endtask

   task automatic read_write_race();
      logic [`AXIL_DATA_W-1:0] old_val;
      logic [`AXIL_DATA_W-1:0] new_val;
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              rresp;
      logic [1:0]              bresp;
      time                     t_rd;
      time                     t_wr;
      test_errs = 0;
      old_val = model[3];
      rng = xorshift32(rng);
      new_val = rng;
      fork
         begin
            axil_write(reg_addr(3), new_val, '1, 0, bresp);
            t_wr = $time;
         end
         begin
            axil_read(reg_addr(3), 0, rd, rresp);
            t_rd = $time;
         end
      join
      model_write(reg_addr(3), new_val, '1);
      if (rd !== old_val) report_mismatch("race first read", old_val, rd);
      if (t_rd >= t_wr) begin
         $display("the write finished before the read it tied with");
         test_errs++;
      end
      axil_read(reg_addr(3), 0, rd, rresp);
      if (rd !== new_val) report_mismatch("race second read", new_val, rd);
      finish_test("read_write_race");
   endtask

   task automatic response_backpressure();
      logic [`AXIL_DATA_W-1:0] rd;
      logic [1:0]              resp;
      test_errs = 0;
      rng = xorshift32(rng);
      axil_write(reg_addr(5), rng, '1, 5, resp);
      model_write(reg_addr(5), rng, '1);
      if (resp !== 2'b00) report_mismatch("backpressure bresp", 32'h0, 32'(resp));
      axil_read(reg_addr(5), 6, rd, resp);
      if (rd !== model[5]) report_mismatch("backpressure read", model[5], rd);
      rng = xorshift32(rng);
      axil_write(reg_addr(6), rng, 4'b0110, 3, resp);
      model_write(reg_addr(6), rng, 4'b0110);
      axil_read(reg_addr(6), 4, rd, resp);
      if (rd !== model[6]) report_mismatch("backpressure partial", model[6], rd);
      finish_test("response_backpressure");
   endtask

   initial begin
      axil_awaddr_i  = '0;
      axil_awvalid_i = 1'b0;
      axil_wdata_i   = '0;
      axil_wstrb_i   = '0;
      axil_wvalid_i  = 1'b0;
      axil_bready_i  = 1'b0;
      axil_araddr_i  = '0;
      axil_arvalid_i = 1'b0;
      axil_rready_i  = 1'b0;
      reset_i        = 1'b1;
      rng            = 32'd5;
      reset_quiet    = 1'b1;
      pass_cnt       = 0;
      fail_cnt       = 0;
      for (int i = 0; i < `REGBANK_N; i++) begin
         model[i] = '0;
      end

      // outputs settle after the first reset edge
      repeat (3) begin
         @(negedge clk_i);
         if (axil_awready_o !== 1'b0 || axil_wready_o !== 1'b0 ||
             axil_arready_o !== 1'b0 || axil_bvalid_o !== 1'b0 ||
             axil_rvalid_o !== 1'b0) begin
            reset_quiet = 1'b0;
         end
      end
      @(posedge clk_i);
      reset_i <= 1'b0;

      check_reset_state();
      write_read_words();
      partial_strobes();
      unmapped_pages();
      read_write_race();
      response_backpressure();

      $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog/axil_iob_top.sv ====
/* AXI4-Lite slave made of the IOb bridge and the register bank */

`timescale 1ns/10ps
`include "axil_iob_params.svh"

module axil_iob_top
   import axil_iob_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,

   input  logic [`AXIL_ADDR_W-1:0] axil_awaddr_i,
   input  logic                   axil_awvalid_i,
   output logic                   axil_awready_o,
   input  logic [`AXIL_DATA_W-1:0] axil_wdata_i,
   input  logic [`AXIL_STRB_W-1:0] axil_wstrb_i,
   input  logic                   axil_wvalid_i,
   output logic                   axil_wready_o,
   output logic [1:0]             axil_bresp_o,
   output logic                   axil_bvalid_o,
   input  logic                   axil_bready_i,
   input  logic [`AXIL_ADDR_W-1:0] axil_araddr_i,
   input  logic                   axil_arvalid_i,
   output logic                   axil_arready_o,
   output logic [`AXIL_DATA_W-1:0] axil_rdata_o,
   output logic [1:0]             axil_rresp_o,
   output logic                   axil_rvalid_o,
   input  logic                   axil_rready_i
);

   // iob link
   logic                    iob_valid;
   iob_addr_u               iob_addr;
   logic [`AXIL_DATA_W-1:0] iob_wdata;
   logic [`AXIL_STRB_W-1:0] iob_wstrb;
   logic                    iob_ready;
   logic                    iob_rvalid;
   logic [`AXIL_DATA_W-1:0] iob_rdata;

   axil2iob_bridge bridge0 (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .axil_awaddr_i  (axil_awaddr_i),
      .axil_awvalid_i (axil_awvalid_i),
      .axil_awready_o (axil_awready_o),
      .axil_wdata_i   (axil_wdata_i),
      .axil_wstrb_i   (axil_wstrb_i),
      .axil_wvalid_i  (axil_wvalid_i),
      .axil_wready_o  (axil_wready_o),
      .axil_bresp_o   (axil_bresp_o),
      .axil_bvalid_o  (axil_bvalid_o),
      .axil_bready_i  (axil_bready_i),
      .axil_araddr_i  (axil_araddr_i),
      .axil_arvalid_i (axil_arvalid_i),
      .axil_arready_o (axil_arready_o),
      .axil_rdata_o   (axil_rdata_o),
      .axil_rresp_o   (axil_rresp_o),
      .axil_rvalid_o  (axil_rvalid_o),
      .axil_rready_i  (axil_rready_i),
      .iob_valid_o    (iob_valid),
      .iob_addr_o     (iob_addr),
      .iob_wdata_o    (iob_wdata),
      .iob_wstrb_o    (iob_wstrb),
      .iob_ready_i    (iob_ready),
      .iob_rvalid_i   (iob_rvalid),
      .iob_rdata_i    (iob_rdata)
   );

   iob_regbank regbank0 (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .iob_valid_i  (iob_valid),
      .iob_addr_i   (iob_addr),
      .iob_wdata_i  (iob_wdata),
      .iob_wstrb_i  (iob_wstrb),
      .iob_ready_o  (iob_ready),
      .iob_rvalid_o (iob_rvalid),
      .iob_rdata_o  (iob_rdata)
   );

endmodule

// ==== verilog/iob_regbank.sv ====
/* IOb register bank, REGBANK_N words with byte strobes,
   wait states before ready and read data one cycle later */

`timescale 1ns/10ps
`include "axil_iob_params.svh"

module iob_regbank
   import axil_iob_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,

   input  logic                   iob_valid_i,
   input  iob_addr_u              iob_addr_i,
   input  logic [`AXIL_DATA_W-1:0] iob_wdata_i,
   input  logic [`AXIL_STRB_W-1:0] iob_wstrb_i,

   output logic                   iob_ready_o,
   output logic                   iob_rvalid_o,
   output logic [`AXIL_DATA_W-1:0] iob_rdata_o
);

   localparam int CNT_W = $clog2(`REGBANK_WAIT + 1);

   logic [`AXIL_DATA_W-1:0] regs [`REGBANK_N];
   logic [CNT_W-1:0]        wait_cnt;
   logic                    accept;
   logic                    is_write;
   logic                    mapped;
   logic                    rd_pend; // ready cycle of a read

   // last wait cycle, command is taken on this edge
   assign accept   = iob_valid_i & ~iob_ready_o &
                     (wait_cnt == CNT_W'(`REGBANK_WAIT - 1));
   assign is_write = |iob_wstrb_i;
   assign mapped   = (iob_addr_i.f.page == '0);

   // pacing of ready and rvalid
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wait_cnt     <= '0;
         iob_ready_o  <= 1'b0;
         rd_pend      <= 1'b0;
         iob_rvalid_o <= 1'b0;
      end else begin
         iob_ready_o  <= accept;
         rd_pend      <= accept & ~is_write;
         iob_rvalid_o <= rd_pend;
         if (iob_valid_i && !iob_ready_o && !accept) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0; // also idle while valid drops after ready
         end
      end
   end

   // strobed writes, unmapped ones dropped
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < `REGBANK_N; i++) begin
            regs[i] <= '0;
         end
      end else if (accept && is_write && mapped) begin
         for (int b = 0; b < `AXIL_STRB_W; b++) begin
            if (iob_wstrb_i[b]) begin
               regs[iob_addr_i.f.index][8*b +: 8] <= iob_wdata_i[8*b +: 8];
            end
         end
      end
   end

   // read data held until the next read
   always_ff @(posedge clk_i) begin
      if (accept && !is_write) begin
         iob_rdata_o <= mapped ? regs[iob_addr_i.f.index] : '0;
      end
   end

endmodule

// ==== verilog/axil2iob_bridge.sv ====
/* AXI4-Lite slave to IOb master bridge
   one transaction at a time, every output registered */

`timescale 1ns/10ps
`include "axil_iob_params.svh"

module axil2iob_bridge
   import axil_iob_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   reset_i,

   // axi write address
   input  logic [`AXIL_ADDR_W-1:0] axil_awaddr_i,
   input  logic                   axil_awvalid_i,
   output logic                   axil_awready_o,
   // axi write data
   input  logic [`AXIL_DATA_W-1:0] axil_wdata_i,
   input  logic [`AXIL_STRB_W-1:0] axil_wstrb_i,
   input  logic                   axil_wvalid_i,
   output logic                   axil_wready_o,
   // axi write response
   output logic [1:0]             axil_bresp_o,
   output logic                   axil_bvalid_o,
   input  logic                   axil_bready_i,
   // axi read address
   input  logic [`AXIL_ADDR_W-1:0] axil_araddr_i,
   input  logic                   axil_arvalid_i,
   output logic                   axil_arready_o,
   // axi read data
   output logic [`AXIL_DATA_W-1:0] axil_rdata_o,
   output logic [1:0]             axil_rresp_o,
   output logic                   axil_rvalid_o,
   input  logic                   axil_rready_i,

   // iob command
   output logic                   iob_valid_o,
   output iob_addr_u              iob_addr_o,
   output logic [`AXIL_DATA_W-1:0] iob_wdata_o,
   output logic [`AXIL_STRB_W-1:0] iob_wstrb_o,
   // iob response
   input  logic                   iob_ready_i,
   input  logic                   iob_rvalid_i,
   input  logic [`AXIL_DATA_W-1:0] iob_rdata_i
);

   localparam logic [2:0] IDLE_ST   = 3'd0;
   localparam logic [2:0] W_DATA_ST = 3'd1; // address taken, waiting wvalid
   localparam logic [2:0] W_IOB_ST  = 3'd2;
   localparam logic [2:0] W_RESP_ST = 3'd3;
   localparam logic [2:0] R_IOB_ST  = 3'd4;
   localparam logic [2:0] R_DATA_ST = 3'd5;
   localparam logic [2:0] R_RESP_ST = 3'd6;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   logic [2:0]              pc;
   logic [2:0]              pc_nxt;

   logic                    awready_nxt;
   logic                    wready_nxt;
   logic                    arready_nxt;
   logic                    bvalid_nxt;
   logic                    rvalid_nxt;
   logic [`AXIL_DATA_W-1:0] rdata_nxt;

   logic                    iob_valid_nxt;
   iob_addr_u               iob_addr_nxt;
   logic [`AXIL_DATA_W-1:0] iob_wdata_nxt;
   logic [`AXIL_STRB_W-1:0] iob_wstrb_nxt;

   // no error responses
   assign axil_bresp_o = RESP_OKAY;
   assign axil_rresp_o = RESP_OKAY;

   always_comb begin
      pc_nxt        = pc;
      awready_nxt   = 1'b0; // readies are single cycle pulses
      wready_nxt    = 1'b0;
      arready_nxt   = 1'b0;
      bvalid_nxt    = axil_bvalid_o;
      rvalid_nxt    = axil_rvalid_o;
      rdata_nxt     = axil_rdata_o;
      iob_valid_nxt = iob_valid_o;
      iob_addr_nxt  = iob_addr_o;
      iob_wdata_nxt = iob_wdata_o;
      iob_wstrb_nxt = iob_wstrb_o;

      case (pc)
         IDLE_ST: begin
            if (axil_arvalid_i) begin // read wins a tie
               arready_nxt       = 1'b1;
               iob_valid_nxt     = 1'b1;
               iob_addr_nxt.word = axil_araddr_i;
               iob_wstrb_nxt     = '0; // zero strobe is a read
               pc_nxt            = R_IOB_ST;
            end else if (axil_awvalid_i) begin
               awready_nxt       = 1'b1;
               iob_addr_nxt.word = axil_awaddr_i;
               if (axil_wvalid_i) begin
                  wready_nxt    = 1'b1;
                  iob_valid_nxt = 1'b1;
                  iob_wdata_nxt = axil_wdata_i;
                  iob_wstrb_nxt = axil_wstrb_i;
                  pc_nxt        = W_IOB_ST;
               end else begin
                  pc_nxt = W_DATA_ST;
               end
            end
         end
         W_DATA_ST: begin
            if (axil_wvalid_i) begin
               wready_nxt    = 1'b1;
               iob_valid_nxt = 1'b1;
               iob_wdata_nxt = axil_wdata_i;
               iob_wstrb_nxt = axil_wstrb_i;
               pc_nxt        = W_IOB_ST;
            end
         end
         W_IOB_ST: begin
            if (iob_ready_i) begin
               iob_valid_nxt = 1'b0;
               bvalid_nxt    = 1'b1;
               pc_nxt        = W_RESP_ST;
            end
         end
         W_RESP_ST: begin
            if (axil_bready_i) begin
               bvalid_nxt = 1'b0;
               pc_nxt     = IDLE_ST;
            end
         end
         R_IOB_ST: begin
            if (iob_ready_i) begin
               iob_valid_nxt = 1'b0;
               pc_nxt        = R_DATA_ST;
            end
         end
         R_DATA_ST: begin
            if (iob_rvalid_i) begin
               rvalid_nxt = 1'b1;
               rdata_nxt  = iob_rdata_i;
               pc_nxt     = R_RESP_ST;
            end
         end
         R_RESP_ST: begin
            if (axil_rready_i) begin // rdata held until here
               rvalid_nxt = 1'b0;
               pc_nxt     = IDLE_ST;
            end
         end
         default: begin
            pc_nxt = IDLE_ST;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      // payload
      iob_addr_o   <= iob_addr_nxt;
      iob_wdata_o  <= iob_wdata_nxt;
      iob_wstrb_o  <= iob_wstrb_nxt;
      axil_rdata_o <= rdata_nxt;

      if (reset_i) begin
         pc             <= IDLE_ST;
         axil_awready_o <= 1'b0;
         axil_wready_o  <= 1'b0;
         axil_arready_o <= 1'b0;
         axil_bvalid_o  <= 1'b0;
         axil_rvalid_o  <= 1'b0;
         iob_valid_o    <= 1'b0;
      end else begin
         pc             <= pc_nxt;
         axil_awready_o <= awready_nxt;
         axil_wready_o  <= wready_nxt;
         axil_arready_o <= arready_nxt;
         axil_bvalid_o  <= bvalid_nxt;
         axil_rvalid_o  <= rvalid_nxt;
         iob_valid_o    <= iob_valid_nxt;
      end
   end

endmodule

// ==== verilog/axil_iob_pkg.sv ====
/* IOb address type, raw word view and decoded field view */

`include "axil_iob_params.svh"

package axil_iob_pkg;

   // field view used by the register bank
   typedef struct packed {
      logic [`AXIL_ADDR_W-6:0] page;     // nonzero means unmapped
      logic [2:0]              index;    // register select
      logic [1:0]              byte_off; // word aligned, not decoded
   } iob_addr_fields_t;

   // bridge moves the word, bank looks at the fields
   typedef union packed {
      logic [`AXIL_ADDR_W-1:0] word;
      iob_addr_fields_t        f;
   } iob_addr_u;

endpackage

// ==== verilog/axil_iob_params.svh ====
/* bus widths, register count and wait states
   shared by the AXI4-Lite to IOb bridge and the register bank */

`ifndef AXIL_IOB_PARAMS_SVH
`define AXIL_IOB_PARAMS_SVH

// byte addressed, same width on AXI4-Lite and IOb
`define AXIL_ADDR_W 8

`define AXIL_DATA_W 32

// one strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// register bank size in words
`define REGBANK_N 8

// cycles the bank waits before iob_ready, at least 1
`define REGBANK_WAIT 2

`endif
